//--- tb/arb_stimulus.txt
// Per test: request matrix as 128-bit hex (row 7 first, 4 digits per row, 2 bits per cell),
// then the command count, then the expected commands {row, col, polarity, repeated} in hex
5
// Row 5 column 2 RESET alone, repeated sweeps
0000_0000_0020_0000_0000_0000_0000_0000
4
AA AA AA AA
// Row 3 full of SET, columns 0 to 7 then wrap
0000_0000_0000_0000_5555_0000_0000_0000
A
60 64 68 6C 70 74 78 7C 60 64
// Rows 1, 4 and 6, row-major order then wrap
0000_0420_0000_0140_0000_0000_8002_0000
8
22 3E 8C 90 CA D4 22 3E
// Row 2 repeat code after RESET and after SET
0000_0000_0000_0000_0000_0D38_0000_0000
6
46 4B 50 55 46 4B
// Row 0 repeat code from reset, row 7 RESET, wrap over the last row
8000_0000_0000_0000_0000_0000_0000_0003
5
01 FE 03 FE 03

//--- project.f
verilog/arb_pkg.sv
verilog/rr_arbiter.sv
verilog/polarity_selector.sv
verilog/grid_arbiter.sv
verilog/pulse_sequencer.sv
verilog/arb_grid_top.sv
tb/arb_grid_checker.sv
tb/arb_grid_tb.sv

//--- Makefile
# Verilator flow for the crosspoint write-pulse controller
# Run from the project root so the stimulus path resolves

TB_TOP := arb_grid_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module arb_grid_top
	verilator --lint-only --timing -f project.f --top-module $(TB_TOP)

# Build, run, and pass only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out="$$(./obj_dir/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

//--- tb/arb_grid_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the crosspoint pulse controller
// Clock, reset, file-driven tests, driver ack model
// Cycle timeout, DUT and checker instances
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module arb_grid_tb;

    localparam int WORD_W         = $bits(arb_pkg::req_matrix_t);
    localparam int STIM_AW        = 6;              // Stimulus memory address width
    localparam int STIM_DEPTH     = 1 << STIM_AW;
    localparam int CYCLES_PER_CMD = 12;             // Budget per expected command
    localparam int CYCLE_MARGIN   = 200;            // Resets, startup and drains
    localparam int IDLE_CYCLES    = 8;              // Quiet window after enable falls

    logic                 clk;
    logic                 reset;
    logic                 enable;
    arb_pkg::req_matrix_t req;
    logic                 cmd_ack;
    arb_pkg::pulse_cmd_t  cmd;
    logic                 cmd_req;
    logic                 busy;

    logic                 test_start;
    logic                 test_end;
    logic                 summary;
    int                   test_num;
    int                   exp_base;                 // Address of the first expected command
    int                   exp_count;
    logic [STIM_AW-1:0]   exp_addr;
    arb_pkg::pulse_cmd_t  exp_cmd;
    int                   seen;
    int                   error_count;

    logic [WORD_W-1:0]    stim_mem [0:STIM_DEPTH-1];
    int                   cycle_limit = 0;
    int                   cycle_count = 0;
    int                   seed        = 60071;

    function automatic logic [WORD_W-1:0] read_stim(input int addr);
        return stim_mem[STIM_AW'(addr)];
    endfunction

    assign exp_addr = STIM_AW'(exp_base + seen);
    assign exp_cmd  = stim_mem[exp_addr][7:0];      // Next command the checker wants

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                      // 10 ns period
    end

    arb_grid_top u_arb_grid_top (
        .clk_i     (clk),
        .reset_i   (reset),
        .enable_i  (enable),
        .req_i     (req),
        .cmd_ack_i (cmd_ack),
        .cmd_o     (cmd),
        .cmd_req_o (cmd_req),
        .busy_o    (busy)
    );

    arb_grid_checker u_arb_grid_checker (
        .clk_i         (clk),
        .test_start_i  (test_start),
        .test_end_i    (test_end),
        .summary_i     (summary),
        .test_num_i    (test_num),
        .exp_count_i   (exp_count),
        .exp_cmd_i     (exp_cmd),
        .cmd_i         (cmd),
        .cmd_req_i     (cmd_req),
        .cmd_ack_i     (cmd_ack),
        .busy_i        (busy),
        .seen_o        (seen),
        .error_count_o (error_count)
    );

    // Pulse driver model, acks each req after 0 to 3 cycles
    initial begin : ack_responder
        int delay;
        cmd_ack <= 1'b0;
        forever begin
            @(posedge clk);
            if (cmd_req) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                cmd_ack <= 1'b1;
                @(posedge clk);
                while (cmd_req) @(posedge clk);     // Hold ack until req falls
                cmd_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: run passed %0d cycles in test %0d with %0d of %0d commands",
                     cycle_limit, test_num, seen, exp_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic run_test(input int num, input int base);
        int count;
        count = int'(read_stim(base + 1));
        @(posedge clk);
        reset      <= 1'b1;
        enable     <= 1'b0;
        req        <= read_stim(base);              // Matrix held through the test
        test_num   <= num;
        exp_base   <= base + 2;
        exp_count  <= count;
        test_start <= 1'b1;
        @(posedge clk);
        test_start <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;                              // Reset high for 5 cycles
        @(posedge clk);
        enable <= 1'b1;
        while (seen < count) @(posedge clk);        // Sweep until the list is covered
        enable <= 1'b0;
        while (busy || cmd_req) @(posedge clk);     // Open handshake drains
        repeat (IDLE_CYCLES) @(posedge clk);        // No command may show up here
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin : run_tests
        int ntests;
        int base;
        int total;
        reset      <= 1'b1;
        enable     <= 1'b0;
        req        <= '0;
        test_start <= 1'b0;
        test_end   <= 1'b0;
        summary    <= 1'b0;
        test_num   <= 0;
        exp_base   <= 0;
        exp_count  <= 0;
        $readmemh("tb/arb_stimulus.txt", stim_mem);
        ntests = int'(read_stim(0));
        base   = 1;
        total  = 0;
        for (int t = 0; t < ntests; t++) begin
            total = total + int'(read_stim(base + 1));
            base  = base + 2 + int'(read_stim(base + 1));
        end
        cycle_limit = total * CYCLES_PER_CMD + CYCLE_MARGIN;
        base        = 1;
        for (int t = 0; t < ntests; t++) begin
            run_test(t + 1, base);
            base = base + 2 + int'(read_stim(base + 1));
        end
        @(posedge clk);
        summary <= 1'b1;
        @(posedge clk);
        summary <= 1'b0;
        @(posedge clk);                             // Counts line is out by now
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb/arb_grid_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command bus checker for the crosspoint testbench
// Expected command compare and four-phase watch
// Per-test result lines and the closing counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module arb_grid_checker (
    input  logic                clk_i,
    input  logic                test_start_i,       // Clear per-test state
    input  logic                test_end_i,         // Test drained, judge it
    input  logic                summary_i,          // Print the totals
    input  int                  test_num_i,
    input  int                  exp_count_i,        // Commands expected in this test
    input  arb_pkg::pulse_cmd_t exp_cmd_i,          // Expected entry at position seen_o
    input  arb_pkg::pulse_cmd_t cmd_i,
    input  logic                cmd_req_i,
    input  logic                cmd_ack_i,
    input  logic                busy_i,
    output int                  seen_o,             // Commands seen in this test
    output int                  error_count_o
);

    int                  seen;
    int                  test_errs    = 0;
    int                  total_errs   = 0;
    int                  tests_passed = 0;
    int                  tests_failed = 0;
    logic                req_q;                     // Previous sample of req
    logic                ack_q;                     // Previous sample of ack
    arb_pkg::pulse_cmd_t held_cmd;                  // Command seen at the req rise

    assign seen_o        = seen;
    assign error_count_o = total_errs;

    initial begin
        seen  <= 0;
        req_q <= 1'b0;
        ack_q <= 1'b0;
    end

    task automatic count_error();
        test_errs  = test_errs + 1;
        total_errs = total_errs + 1;
    endtask

    task automatic judge_test();
        if (seen != exp_count_i) begin
            $display("test %0d: saw %0d commands where %0d were expected",
                     test_num_i, seen, exp_count_i);
            count_error();
        end
        if (cmd_req_i !== 1'b0) begin
            $display("FAILED cmd_req_o: expected 0x0 got 0x%h", cmd_req_i);
            count_error();
        end
        if (busy_i !== 1'b0) begin
            $display("FAILED busy_o: expected 0x0 got 0x%h", busy_i);
            count_error();
        end
        if (test_errs == 0) begin
            tests_passed = tests_passed + 1;
            $display("test %0d passed, %0d commands", test_num_i, seen);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d failed, %0d errors", test_num_i, test_errs);
        end
    endtask

    always @(posedge clk_i) begin
        if (test_start_i) begin
            seen      <= 0;
            test_errs = 0;
        end else if (cmd_req_i && !req_q) begin      // Req rise, one serviced cell
            if (cmd_ack_i) begin
                $display("test %0d: request rose while acknowledge was still high",
                         test_num_i);
                count_error();
            end
            if (seen >= exp_count_i) begin
                $display("test %0d: command 0x%h appeared after the expected list ended",
                         test_num_i, cmd_i);
                count_error();
            end else if (cmd_i !== exp_cmd_i) begin
                $display("FAILED cmd_o: test %0d entry %0d expected 0x%h got 0x%h",
                         test_num_i, seen, exp_cmd_i, cmd_i);
                count_error();
            end
            held_cmd <= cmd_i;
            seen     <= seen + 1;
        end else if (cmd_req_i && (cmd_i !== held_cmd)) begin
            $display("FAILED cmd_o: changed while request high, expected 0x%h got 0x%h",
                     held_cmd, cmd_i);
            count_error();
        end else if (!cmd_req_i && req_q && !ack_q) begin
            $display("test %0d: request fell before acknowledge was seen", test_num_i);
            count_error();
        end
        if (test_end_i) begin
            judge_test();
        end
        if (summary_i) begin
            $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                     tests_passed + tests_failed, tests_passed, tests_failed, total_errs);
        end
        req_q <= cmd_req_i;
        ack_q <= cmd_ack_i;
    end

endmodule

//--- verilog/arb_grid_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crosspoint write-pulse controller top level
// Grid arbiter, polarity selector, pulse sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module arb_grid_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,
    input  arb_pkg::req_matrix_t req_i,
    input  logic                 cmd_ack_i,
    output arb_pkg::pulse_cmd_t  cmd_o,
    output logic                 cmd_req_o,
    output logic                 busy_o
);

    arb_pkg::cell_grant_t grant;                    // Cell picked by the arbiter
    logic                 cell_valid;
    logic                 cell_done;
    logic                 polarity;
    logic                 repeated;

    grid_arbiter u_grid_arbiter (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .req_i        (req_i),
        .cell_done_i  (cell_done),
        .grant_o      (grant),
        .cell_valid_o (cell_valid),
        .busy_o       (busy_o)
    );

    polarity_selector u_polarity_selector (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .code_i     (grant.code),
        .update_i   (cell_done),                    // Remember polarity once pulse is out
        .polarity_o (polarity),
        .repeated_o (repeated)
    );

    pulse_sequencer u_pulse_sequencer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cell_valid_i (cell_valid),
        .grant_i      (grant),
        .polarity_i   (polarity),
        .repeated_i   (repeated),
        .cmd_ack_i    (cmd_ack_i),
        .cmd_o        (cmd_o),
        .cmd_req_o    (cmd_req_o),
        .cell_done_o  (cell_done)
    );

endmodule

//--- verilog/pulse_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pulse sequencer
// Command register and four-phase req/ack to driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pulse_sequencer (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 cell_valid_i,      // New cell from the arbiter
    input  arb_pkg::cell_grant_t grant_i,
    input  logic                 polarity_i,
    input  logic                 repeated_i,
    input  logic                 cmd_ack_i,         // Driver acknowledge
    output arb_pkg::pulse_cmd_t  cmd_o,
    output logic                 cmd_req_o,
    output logic                 cell_done_o        // One cycle after ack low
);

    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'b00,
        SEQ_REQ     = 2'b01,                        // req high, waiting for ack
        SEQ_RELEASE = 2'b10                         // req low, waiting for ack low
    } seq_state_t;

    seq_state_t          state_q;
    arb_pkg::pulse_cmd_t cmd_q;
    logic                done_q;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_q <= SEQ_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                SEQ_IDLE:    if (cell_valid_i) state_q <= SEQ_REQ;
                SEQ_REQ:     if (cmd_ack_i) state_q <= SEQ_RELEASE;
                SEQ_RELEASE: begin
                    if (!cmd_ack_i) begin
                        state_q <= SEQ_IDLE;
                        done_q  <= 1'b1;            // Handshake closed
                    end
                end
                default:     state_q <= SEQ_IDLE;
            endcase
        end
    end

    // Command frozen from cell_valid until the next cell
    always_ff @(posedge clk_i) begin
        if (state_q == SEQ_IDLE && cell_valid_i) begin
            cmd_q.row      <= grant_i.row;
            cmd_q.col      <= grant_i.col;
            cmd_q.polarity <= polarity_i;
            cmd_q.repeated <= repeated_i;
        end
    end

    assign cmd_o       = cmd_q;
    assign cmd_req_o   = (state_q == SEQ_REQ);
    assign cell_done_o = done_q;

    a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(cmd_req_o) |-> $past(cmd_ack_i))
        else $error("cmd_req_o dropped before cmd_ack_i");

    // Arbiter must not offer a cell while a handshake is open
    a_valid_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        cell_valid_i |-> (state_q == SEQ_IDLE))
        else $error("cell_valid_i during an open handshake");

endmodule

//--- verilog/grid_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-level row/column arbiter for the crosspoint
// IDLE, ROW_GRANT, COL_GRANT machine, one cell at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module grid_arbiter (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,          // Keep sweeping while high
    input  arb_pkg::req_matrix_t req_i,             // Per-cell request codes
    input  logic                 cell_done_i,       // Handshake of current cell closed
    output arb_pkg::cell_grant_t grant_o,
    output logic                 cell_valid_o,      // grant_o is a new cell
    output logic                 busy_o
);

    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        ROW_GRANT = 2'b01,
        COL_GRANT = 2'b10
    } state_t;

    state_t                   state_q;
    logic                     wait_q;               // Cell issued, waiting for done
    logic [arb_pkg::ROW_W-1:0] row_q;               // Row owning the column level

    logic [arb_pkg::ROWS-1:0] row_req;
    logic [arb_pkg::ROWS-1:0] row_gnt;
    logic [arb_pkg::ROW_W-1:0] row_idx;
    logic                     row_en;
    logic [arb_pkg::COLS-1:0] col_req;
    logic [arb_pkg::COLS-1:0] col_gnt;
    logic [arb_pkg::COL_W-1:0] col_idx;
    logic                     col_en;
    logic                     col_release;          // Row fully served
    arb_pkg::pol_code_t       cur_code;

    // Row requests, any code in the row
    always_comb begin
        for (int r = 0; r < arb_pkg::ROWS; r++) begin
            row_req[r] = |req_i[r];
        end
    end

    // Column requests of the granted row
    always_comb begin
        for (int c = 0; c < arb_pkg::COLS; c++) begin
            col_req[c] = |req_i[row_q][c];
        end
    end

    assign row_en   = (state_q == ROW_GRANT) && enable_i;
    assign col_en   = (state_q == COL_GRANT) && !wait_q && enable_i;
    assign cur_code = req_i[row_q][col_idx];

    assign grant_o.row  = row_q;
    assign grant_o.col  = col_idx;
    assign grant_o.code = cur_code;

    assign cell_valid_o = (|col_gnt) && (cur_code != arb_pkg::CODE_NONE);
    assign busy_o       = (state_q != IDLE) || wait_q;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            wait_q  <= 1'b0;
            row_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    wait_q <= 1'b0;
                    if (enable_i) state_q <= ROW_GRANT;
                end
                ROW_GRANT: begin
                    if (!enable_i) begin
                        state_q <= IDLE;
                    end else if (|row_gnt) begin
                        row_q   <= row_idx;         // Lock the row for column level
                        state_q <= COL_GRANT;
                    end
                end
                COL_GRANT: begin
                    if (wait_q) begin
                        if (cell_done_i) wait_q <= 1'b0;  // Stall here on slow ack
                    end else if (!enable_i) begin
                        state_q <= IDLE;
                    end else if (col_release) begin
                        state_q <= ROW_GRANT;       // Back to the row level
                    end else if (cell_valid_o) begin
                        wait_q <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    rr_arbiter #(.N(arb_pkg::ROWS)) u_row_arb (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (row_en),
        .advance_i     (col_release),               // Row served once all columns are
        .req_i         (row_req),
        .gnt_o         (row_gnt),
        .idx_o         (row_idx),
        .grp_release_o ()                           // Wrap is handled inside
    );

    rr_arbiter #(.N(arb_pkg::COLS)) u_col_arb (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (col_en),
        .advance_i     (cell_done_i),               // One pulse per column
        .req_i         (col_req),
        .gnt_o         (col_gnt),
        .idx_o         (col_idx),
        .grp_release_o (col_release)
    );

endmodule

//--- verilog/polarity_selector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Polarity selector
// Code to pulse polarity, with last polarity memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module polarity_selector (
    input  logic               clk_i,
    input  logic               reset_i,
    input  arb_pkg::pol_code_t code_i,              // Code of the granted cell
    input  logic               update_i,            // Pulse finished, store polarity
    output logic               polarity_o,
    output logic               repeated_o
);

    logic last_pol_q;                               // Polarity of the previous pulse

    always_comb begin
        polarity_o = 1'b0;
        repeated_o = 1'b0;
        case (code_i)
            arb_pkg::CODE_SET:    polarity_o = 1'b0;
            arb_pkg::CODE_RESET:  polarity_o = 1'b1;
            arb_pkg::CODE_REPEAT: begin
                polarity_o = last_pol_q;            // Same as last pulse
                repeated_o = 1'b1;
            end
            default:              polarity_o = 1'b0; // No request
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            last_pol_q <= 1'b0;
        end else if (update_i) begin
            last_pol_q <= polarity_o;
        end
    end

endmodule

//--- verilog/rr_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter, width parameterized
// Served mask, index output and group release
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int N = arb_pkg::ROWS                 // Number of requesters
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,          // Grant and release qualifier
    input  logic                 advance_i,         // Current grant has been served
    input  logic [N-1:0]         req_i,
    output logic [N-1:0]         gnt_o,             // One-hot grant
    output logic [$clog2(N)-1:0] idx_o,             // Index of the grant
    output logic                 grp_release_o      // Every request of the group served
);

    localparam int IDX_W = $clog2(N);

    logic [N-1:0]     served_q;                     // Served in the current group
    logic [IDX_W-1:0] ptr_q;                        // Search start position
    logic [N-1:0]     avail;                        // Requesting and not yet served
    logic [N-1:0]     gnt;
    logic [IDX_W-1:0] idx;
    logic             found;

    assign avail = req_i & ~served_q;

    // First available position at or after the pointer, wrapping
    always_comb begin
        int pos;
        gnt   = '0;
        idx   = '0;
        found = 1'b0;
        pos   = 0;
        for (int i = 0; i < N; i++) begin
            pos = (int'(ptr_q) + i) % N;
            if (!found && avail[pos]) begin
                found    = 1'b1;
                gnt[pos] = 1'b1;
                idx      = IDX_W'(pos);
            end
        end
    end

    assign gnt_o         = enable_i ? gnt : '0;
    assign idx_o         = idx;                     // Held stable while parent waits
    assign grp_release_o = enable_i && !found;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            served_q <= '0;
            ptr_q    <= '0;
        end else if (grp_release_o) begin
            served_q <= '0;                         // New group
            ptr_q    <= '0;                         // Restart from lowest index
        end else if (advance_i && found) begin
            served_q <= served_q | gnt;
            ptr_q    <= (int'(idx) == N-1) ? '0 : idx + 1'b1;  // Step past the grant
        end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o))
        else $error("rr_arbiter grant is not one-hot");

    // The parent may only retire a grant that is still pending
    a_adv_pending: assert property (@(posedge clk_i) disable iff (reset_i)
        advance_i |-> found)
        else $error("rr_arbiter advanced with no pending grant");

endmodule

//--- verilog/arb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crosspoint write-pulse controller package
// Array sizes, index widths and polarity codes
// Request matrix, granted cell and pulse command types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package arb_pkg;

    localparam int ROWS  = 8;                       // Array rows
    localparam int COLS  = 8;                       // Array columns
    localparam int ROW_W = 3;                       // Row index width
    localparam int COL_W = 3;                       // Column index width
    localparam int POL_W = 2;                       // Cell request code width

    // Cell request code, one per crosspoint
    typedef logic [POL_W-1:0] pol_code_t;

    localparam pol_code_t CODE_NONE   = 2'b00;      // Idle cell
    localparam pol_code_t CODE_SET    = 2'b01;      // SET pulse, polarity 0
    localparam pol_code_t CODE_RESET  = 2'b10;      // RESET pulse, polarity 1
    localparam pol_code_t CODE_REPEAT = 2'b11;      // Reuse previous polarity

    // Full request matrix, 128 bits
    typedef pol_code_t [ROWS-1:0][COLS-1:0] req_matrix_t;

    // Cell handed from arbiter to selector and sequencer
    typedef struct packed {
        logic [ROW_W-1:0] row;                      // Granted row
        logic [COL_W-1:0] col;                      // Granted column
        pol_code_t        code;                     // Raw request code
    } cell_grant_t;

    // Payload of the command bus to the pulse driver
    typedef struct packed {
        logic [ROW_W-1:0] row;                      // Target row
        logic [COL_W-1:0] col;                      // Target column
        logic             polarity;                 // 0 SET, 1 RESET
        logic             repeated;                 // Code was 11
    } pulse_cmd_t;

endpackage
